// File: common/SegPkg.sv
// Shared types, glyph codes and constants for the seven-segment display RTL and its testbench
package SegPkg;

    // ------------------------------------------------------------------------
    // Widths that carry a meaning
    // ------------------------------------------------------------------------

    // One displayed character
    typedef logic [4:0] glyphT;
    // Segment pattern, bit 0 = a up to bit 6 = g
    typedef logic [6:0] segT;
    // One-hot digit enable
    typedef logic [5:0] digitEnT;
    // Digit position 0..5
    typedef logic [2:0] digitIdxT;
    // Value shown as one hex digit
    typedef logic [3:0] nibbleT;
    // Value shown as two hex digits
    typedef logic [7:0] byteT;

    // BIOS banner rotation FSM
    typedef enum logic [1:0] {
        BannerCurrent = 2'd0,
        BannerNext    = 2'd1,
        BannerActive  = 2'd2
    } bannerSelT;

    // ------------------------------------------------------------------------
    // Scan geometry
    // ------------------------------------------------------------------------
    localparam int       NumDigits = 6;
    // Scan wraps back to 0 after this position
    localparam digitIdxT LastDigit = 3'd5;

    // ------------------------------------------------------------------------
    // Glyph codes
    // ------------------------------------------------------------------------
    // Codes 0x00..0x0F are the hex digits themselves
    localparam glyphT GlyphBlank      = 5'h10;
    localparam glyphT GlyphDash       = 5'h11;
    localparam glyphT GlyphDoubleBar  = 5'h12;
    localparam glyphT GlyphSmallN     = 5'h13;
    // Also what any unknown code shows
    localparam glyphT GlyphUnderscore = 5'h14;
    // Banner letters reuse the hex codes
    localparam glyphT GlyphA          = 5'h0A;
    localparam glyphT GlyphB          = 5'h0B;
    localparam glyphT GlyphC          = 5'h0C;

    // ------------------------------------------------------------------------
    // Fixed display content
    // ------------------------------------------------------------------------
    // All segments lit, lamp test look after reset
    localparam segT    SegAllOn    = 7'h7F;
    // Shown in digits 0 and 1 outside software mode
    localparam nibbleT VersionCode = 4'h1;
    localparam nibbleT FpgaIdCode  = 4'h3;
    // Modulate phase in which the running-BIOS banner goes dark
    localparam logic [1:0] BlinkOffPhase = 2'd2;

endpackage

// File: scan/SegGlyphDecode.sv
// Glyph to segment lookup for the display's character set, purely combinational
`timescale 1ns/10ps

module SegGlyphDecode (
    input  SegPkg::glyphT Glyph,
    output SegPkg::segT   Seg
);
    import SegPkg::*;

    // Bit order g f e d c b a, bit 0 = a
    always_comb begin
        case (Glyph)
            // Hex digits
            5'h00: Seg = 7'h3F;
            5'h01: Seg = 7'h06;
            5'h02: Seg = 7'h5B;
            5'h03: Seg = 7'h4F;
            5'h04: Seg = 7'h66;
            5'h05: Seg = 7'h6D;
            5'h06: Seg = 7'h7D;
            5'h07: Seg = 7'h27;
            5'h08: Seg = 7'h7F;
            5'h09: Seg = 7'h67;
            // Letters A..F, b and d lower case
            5'h0A: Seg = 7'h77;
            5'h0B: Seg = 7'h7C;
            5'h0C: Seg = 7'h39;
            5'h0D: Seg = 7'h5E;
            5'h0E: Seg = 7'h79;
            5'h0F: Seg = 7'h71;
            // Special characters
            GlyphBlank:     Seg = 7'h00;
            // Middle bar only
            GlyphDash:      Seg = 7'h40;
            // Middle and bottom bars
            GlyphDoubleBar: Seg = 7'h48;
            GlyphSmallN:    Seg = 7'h54;
            // Bottom bar, also shown for any unknown code
            GlyphUnderscore: Seg = 7'h08;
            default:         Seg = 7'h08;
        endcase
    end

endmodule

// File: scan/SegScanner.sv
// Display scanner: turns the 1 ms strobe into a scan tick and walks the six digits onto the pins
`timescale 1ns/10ps

module SegScanner (
    input  logic            Mclk,
    input  logic            ResetN,
    input  logic            Strobe1ms,
    input  SegPkg::glyphT   Digits [SegPkg::NumDigits],
    output logic            ScanTick,
    output SegPkg::digitEnT Led7En,
    output SegPkg::segT     Led7Leg
);
    import SegPkg::*;

    logic     strobeSync1;
    logic     strobeSync2;
    digitIdxT scanPos;
    glyphT    stageGlyph;
    digitEnT  stageEn;
    segT      stageSeg;

    // ------------------------------------------------------------------------
    // Tick detect
    // ------------------------------------------------------------------------
    always_ff @(posedge Mclk or negedge ResetN) begin
        if (!ResetN) begin
            strobeSync1 <= 1'b0;
            strobeSync2 <= 1'b0;
        end else begin
            strobeSync1 <= Strobe1ms;
            strobeSync2 <= strobeSync1;
        end
    end

    // Rising edge of the delayed strobe, one cycle wide
    assign ScanTick = strobeSync1 && !strobeSync2;

    // ------------------------------------------------------------------------
    // Position and output pipeline
    // ------------------------------------------------------------------------
    // Stage holds position N while the pins still show N-1,
    // so enable and segments always move together
    always_ff @(posedge Mclk or negedge ResetN) begin
        if (!ResetN) begin
            scanPos    <= '0;
            stageGlyph <= '0;
            stageEn    <= '0;
            Led7En     <= '0;
            Led7Leg    <= SegAllOn;
        end else if (ScanTick) begin
            scanPos    <= (scanPos == LastDigit) ? digitIdxT'(0) : scanPos + 3'd1;
            stageGlyph <= Digits[scanPos];
            stageEn    <= digitEnT'(1) << scanPos;
            Led7En     <= stageEn;
            Led7Leg    <= stageSeg;
        end
    end

    // Segments for the staged glyph
    SegGlyphDecode uGlyphDecode (
        .Glyph (stageGlyph),
        .Seg   (stageSeg)
    );

    assert property (@(posedge Mclk) disable iff (!ResetN) scanPos <= LastDigit);

    // At most one digit driven at a time
    assert property (@(posedge Mclk) disable iff (!ResetN) $onehot0(Led7En));

endmodule

// File: rtl/SegBiosBanner.sv
// BIOS banner source: builds the two banner glyphs, rotating after BIOS is done and blinking before
`timescale 1ns/10ps

module SegBiosBanner (
    input  logic          Mclk,
    input  logic          ResetN,
    input  logic          BiosFinished,
    input  logic [2:0]    BiosStatus,
    input  logic          Strobe1s,
    input  logic          Strobe125ms,
    output SegPkg::glyphT BannerHi,
    output SegPkg::glyphT BannerLo
);
    import SegPkg::*;

    bannerSelT  bannerSel;
    logic [1:0] modulate;
    logic       blinkOn;
    glyphT      glyphHi;
    glyphT      glyphLo;

    // ------------------------------------------------------------------------
    // Slow counters
    // ------------------------------------------------------------------------

    // Blink phase, one step per 125 ms
    always_ff @(posedge Mclk or negedge ResetN) begin
        if (!ResetN) begin
            modulate <= 2'd0;
        end else if (Strobe125ms) begin
            modulate <= modulate + 2'd1;
        end
    end

    // Rotation Current -> Next -> Active, once a second after BIOS is done
    always_ff @(posedge Mclk or negedge ResetN) begin
        if (!ResetN) begin
            bannerSel <= BannerCurrent;
        end else if (BiosFinished && Strobe1s) begin
            case (bannerSel)
                BannerCurrent: bannerSel <= BannerNext;
                BannerNext:    bannerSel <= BannerActive;
                default:       bannerSel <= BannerCurrent;
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // Banner glyphs, refreshed every cycle
    // ------------------------------------------------------------------------
    always_ff @(posedge Mclk or negedge ResetN) begin
        if (!ResetN) begin
            glyphHi <= '0;
            glyphLo <= '0;
            blinkOn <= 1'b1;
        end else begin
            // Never dark once BIOS is done
            blinkOn <= BiosFinished || (modulate != BlinkOffPhase);
            if (!BiosFinished) begin
                // Still booting: "b" plus current-BIOS bit
                glyphHi <= GlyphB;
                glyphLo <= glyphT'(BiosStatus[2]);
            end else begin
                case (bannerSel)
                    BannerCurrent: begin
                        glyphHi <= GlyphC;
                        glyphLo <= glyphT'(BiosStatus[2]);
                    end
                    BannerNext: begin
                        glyphHi <= GlyphSmallN;
                        glyphLo <= glyphT'(BiosStatus[1]);
                    end
                    default: begin
                        glyphHi <= GlyphA;
                        glyphLo <= glyphT'(BiosStatus[0]);
                    end
                endcase
            end
        end
    end

    assign BannerHi = blinkOn ? glyphHi : GlyphBlank;
    assign BannerLo = blinkOn ? glyphLo : GlyphBlank;

    // FSM must never reach the unused fourth encoding
    assert property (@(posedge Mclk) disable iff (!ResetN)
        bannerSel inside {BannerCurrent, BannerNext, BannerActive});

endmodule

// File: rtl/SegDigitStore.sv
// Digit store: holds the six glyphs and the decimal point, reloaded per display mode on each scan tick
`timescale 1ns/10ps

module SegDigitStore (
    input  logic           Mclk,
    input  logic           ResetN,
    input  logic           ScanTick,
    input  logic           SystemOk,
    input  logic           AllPwrGd,
    input  logic           SoftEn,
    input  logic [2:0]     SoftSel,
    input  SegPkg::byteT   SoftVal,
    input  SegPkg::byteT   BiosPostData,
    input  SegPkg::nibbleT PowerEvtState,
    input  SegPkg::nibbleT DebugNibble,
    input  SegPkg::glyphT  BannerHi,
    input  SegPkg::glyphT  BannerLo,
    output SegPkg::glyphT  Digits [SegPkg::NumDigits],
    output logic           Port80Dp
);
    import SegPkg::*;

    // ------------------------------------------------------------------------
    // Digit registers
    // ------------------------------------------------------------------------
    // Modes, checked in order
    //   SystemOk            software writes
    //   AllPwrGd, !SystemOk post
    //   neither             standby
    always_ff @(posedge Mclk or negedge ResetN) begin
        if (!ResetN) begin
            for (int i = 0; i < NumDigits; i++) begin
                Digits[i] <= '0;
            end
        end else if (ScanTick) begin
            if (SystemOk) begin
                // Firmware owns the display, pairs picked by SoftSel
                if (SoftEn) begin
                    for (int k = 0; k < NumDigits / 2; k++) begin
                        if (SoftSel[k]) begin
                            Digits[2*k]   <= glyphT'(SoftVal[3:0]);
                            Digits[2*k+1] <= glyphT'(SoftVal[7:4]);
                        end
                    end
                end
            end else begin
                // Version and id always lead
                Digits[0] <= glyphT'(VersionCode);
                Digits[1] <= glyphT'(FpgaIdCode);
                // BIOS banner in the middle
                Digits[2] <= BannerLo;
                Digits[3] <= BannerHi;
                if (AllPwrGd) begin
                    // Port-80 POST code
                    Digits[4] <= glyphT'(BiosPostData[3:0]);
                    Digits[5] <= glyphT'(BiosPostData[7:4]);
                end else begin
                    // Standby debug view
                    Digits[4] <= glyphT'(PowerEvtState);
                    Digits[5] <= glyphT'(DebugNibble);
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // Decimal point
    // ------------------------------------------------------------------------

    // Lit in standby only; software mode leaves it alone
    always_ff @(posedge Mclk or negedge ResetN) begin
        if (!ResetN) begin
            Port80Dp <= 1'b0;
        end else if (ScanTick && !SystemOk) begin
            Port80Dp <= !AllPwrGd;
        end
    end

endmodule

// File: rtl/Led7SegDisplay.sv
// Top of the six-digit multiplexed LED display: banner source, digit store and scanner in a row
`timescale 1ns/10ps

module Led7SegDisplay (
    input  logic            Mclk,
    input  logic            ResetN,
    input  logic            AllPwrGd,
    input  logic            SystemOk,
    input  logic            BiosFinished,
    input  SegPkg::byteT    BiosPostData,
    input  logic            Strobe1ms,
    input  logic            Strobe1s,
    input  logic            Strobe125ms,
    input  logic [2:0]      BiosStatus,
    input  logic            SoftEn,
    input  logic [2:0]      SoftSel,
    input  SegPkg::byteT    SoftVal,
    input  SegPkg::nibbleT  PowerEvtState,
    input  SegPkg::nibbleT  DebugNibble,
    output SegPkg::digitEnT Led7En,
    output SegPkg::segT     Led7Leg,
    output logic            Port80Dp
);
    import SegPkg::*;

    // ------------------------------------------------------------------------
    // Internal links
    // ------------------------------------------------------------------------
    logic  scanTick;
    glyphT bannerHi;
    glyphT bannerLo;
    glyphT digits [NumDigits];

    // BIOS banner glyphs for digits 2 and 3
    SegBiosBanner uBiosBanner (
        .Mclk         (Mclk),
        .ResetN       (ResetN),
        .BiosFinished (BiosFinished),
        .BiosStatus   (BiosStatus),
        .Strobe1s     (Strobe1s),
        .Strobe125ms  (Strobe125ms),
        .BannerHi     (bannerHi),
        .BannerLo     (bannerLo)
    );

    // Mode-dependent digit contents
    SegDigitStore uDigitStore (
        .Mclk          (Mclk),
        .ResetN        (ResetN),
        .ScanTick      (scanTick),
        .SystemOk      (SystemOk),
        .AllPwrGd      (AllPwrGd),
        .SoftEn        (SoftEn),
        .SoftSel       (SoftSel),
        .SoftVal       (SoftVal),
        .BiosPostData  (BiosPostData),
        .PowerEvtState (PowerEvtState),
        .DebugNibble   (DebugNibble),
        .BannerHi      (bannerHi),
        .BannerLo      (bannerLo),
        .Digits        (digits),
        .Port80Dp      (Port80Dp)
    );

    // Multiplexing onto the pins
    SegScanner uScanner (
        .Mclk      (Mclk),
        .ResetN    (ResetN),
        .Strobe1ms (Strobe1ms),
        .Digits    (digits),
        .ScanTick  (scanTick),
        .Led7En    (Led7En),
        .Led7Leg   (Led7Leg)
    );

endmodule

// File: bench/tbLed7Seg.sv
// Self-checking testbench for the six-digit LED display top; run from the project root with list.f
`timescale 1ns/10ps

module tbLed7Seg;
    import SegPkg::*;

    logic       Mclk;
    logic       ResetN;
    logic       AllPwrGd;
    logic       SystemOk;
    logic       BiosFinished;
    byteT       BiosPostData;
    logic       Strobe1ms;
    logic       Strobe1s;
    logic       Strobe125ms;
    logic [2:0] BiosStatus;
    logic       SoftEn;
    logic [2:0] SoftSel;
    byteT       SoftVal;
    nibbleT     PowerEvtState;
    nibbleT     DebugNibble;
    digitEnT    Led7En;
    segT        Led7Leg;
    logic       Port80Dp;

    // Checker state
    string       testName;
    logic        checkEn;
    logic        strobeRun;
    int          errorCount;
    int          checkCount;

    // Testbench view of the store and banner
    glyphT      storeModel [NumDigits];
    logic       dpModel;
    int         selModel;
    logic [1:0] modModel;

    Led7SegDisplay uut (
        .Mclk          (Mclk),
        .ResetN        (ResetN),
        .AllPwrGd      (AllPwrGd),
        .SystemOk      (SystemOk),
        .BiosFinished  (BiosFinished),
        .BiosPostData  (BiosPostData),
        .Strobe1ms     (Strobe1ms),
        .Strobe1s      (Strobe1s),
        .Strobe125ms   (Strobe125ms),
        .BiosStatus    (BiosStatus),
        .SoftEn        (SoftEn),
        .SoftSel       (SoftSel),
        .SoftVal       (SoftVal),
        .PowerEvtState (PowerEvtState),
        .DebugNibble   (DebugNibble),
        .Led7En        (Led7En),
        .Led7Leg       (Led7Leg),
        .Port80Dp      (Port80Dp)
    );

    // 40 ns clock
    always #20 Mclk = ~Mclk;

    // 1 ms strobe stand-in, one cycle high every 8
    always begin
        @(negedge Mclk);
        if (strobeRun) begin
            Strobe1ms = 1'b1;
            @(negedge Mclk);
            Strobe1ms = 1'b0;
            repeat (6) @(negedge Mclk);
        end
    end

    // ------------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------------

    // Character set, bit 0 = segment a
    function automatic segT refSeg(input glyphT g);
        case (g)
            5'h00: return 7'h3F;
            5'h01: return 7'h06;
            5'h02: return 7'h5B;
            5'h03: return 7'h4F;
            5'h04: return 7'h66;
            5'h05: return 7'h6D;
            5'h06: return 7'h7D;
            5'h07: return 7'h27;
            5'h08: return 7'h7F;
            5'h09: return 7'h67;
            5'h0A: return 7'h77;
            5'h0B: return 7'h7C;
            5'h0C: return 7'h39;
            5'h0D: return 7'h5E;
            5'h0E: return 7'h79;
            5'h0F: return 7'h71;
            5'h10: return 7'h00;
            5'h11: return 7'h40;
            5'h12: return 7'h48;
            5'h13: return 7'h54;
            default: return 7'h08;
        endcase
    endfunction

    // Glyph a position should show once the inputs have settled
    function automatic glyphT expectedGlyph(input int pos);
        glyphT hi;
        glyphT lo;
        glyphT result;
        // Banner pair
        if (!BiosFinished) begin
            hi = GlyphB;
            lo = glyphT'(BiosStatus[2]);
        end else if (selModel == 0) begin
            hi = GlyphC;
            lo = glyphT'(BiosStatus[2]);
        end else if (selModel == 1) begin
            hi = GlyphSmallN;
            lo = glyphT'(BiosStatus[1]);
        end else begin
            hi = GlyphA;
            lo = glyphT'(BiosStatus[0]);
        end
        // Dark phase of the boot blink
        if (!BiosFinished && modModel == BlinkOffPhase) begin
            hi = GlyphBlank;
            lo = GlyphBlank;
        end
        case (pos)
            0: result = glyphT'(VersionCode);
            1: result = glyphT'(FpgaIdCode);
            2: result = lo;
            3: result = hi;
            4: result = AllPwrGd ? glyphT'(BiosPostData[3:0]) : glyphT'(PowerEvtState);
            5: result = AllPwrGd ? glyphT'(BiosPostData[7:4]) : glyphT'(DebugNibble);
            default: result = GlyphUnderscore;
        endcase
        // Firmware owns every digit in software mode
        if (SystemOk) begin
            result = storeModel[pos];
        end
        return result;
    endfunction

    function automatic logic expectedDp();
        if (SystemOk) begin
            return dpModel;
        end
        return !AllPwrGd;
    endfunction

    function automatic int enPos(input digitEnT en);
        int result;
        result = 0;
        for (int i = 0; i < NumDigits; i++) begin
            if (en[i]) begin
                result = i;
            end
        end
        return result;
    endfunction

    // ------------------------------------------------------------------------
    // Checking
    // ------------------------------------------------------------------------
    task automatic checkValue(input string name, input logic [7:0] expected,
                              input logic [7:0] actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("Fail %s expected %h actual %h", name, expected, actual);
        end
    endtask

    // Quarter period after the rising edge, clear of output and input changes
    always begin
        @(posedge Mclk);
        #10;
        if (checkEn && $onehot(Led7En)) begin
            checkValue(testName, 8'(refSeg(expectedGlyph(enPos(Led7En)))), 8'(Led7Leg));
            checkValue({testName, " dp"}, 8'(expectedDp()), 8'(Port80Dp));
        end
    end

    // One scan step seen on the pins, bounded
    task automatic waitEnChange();
        digitEnT prev;
        int      cycles;
        prev = Led7En;
        cycles = 0;
        do begin
            @(posedge Mclk);
            #10;
            cycles++;
        end while (Led7En == prev && cycles < 40);
        if (Led7En == prev) begin
            errorCount++;
            $display("Timeout in %s, Led7En did not change within 40 cycles", testName);
        end
    endtask

    // Two full scan rounds
    task automatic settle();
        repeat (2 * NumDigits) waitEnChange();
    endtask

    task automatic checkRound();
        checkEn = 1'b1;
        repeat (2 * NumDigits) waitEnChange();
        checkEn = 1'b0;
    endtask

    task automatic pulseStrobe1s();
        @(negedge Mclk);
        Strobe1s = 1'b1;
        @(negedge Mclk);
        Strobe1s = 1'b0;
        if (BiosFinished) begin
            selModel = (selModel + 1) % 3;
        end
    endtask

    task automatic pulseStrobe125ms();
        @(negedge Mclk);
        Strobe125ms = 1'b1;
        @(negedge Mclk);
        Strobe125ms = 1'b0;
        modModel = modModel + 2'd1;
    endtask

    // Snapshot of the store before firmware takes over
    task automatic latchStore();
        for (int i = 0; i < NumDigits; i++) begin
            storeModel[i] = expectedGlyph(i);
        end
        dpModel = !AllPwrGd;
    endtask

    task automatic applySoft();
        @(negedge Mclk);
        SystemOk = 1'b1;
        SoftEn   = 1'b1;
        SoftSel  = 3'($urandom);
        SoftVal  = 8'($urandom);
        // Power-good moves under firmware, the point must hold
        AllPwrGd = !AllPwrGd;
        for (int k = 0; k < NumDigits / 2; k++) begin
            if (SoftSel[k]) begin
                storeModel[2*k]   = glyphT'(SoftVal[3:0]);
                storeModel[2*k+1] = glyphT'(SoftVal[7:4]);
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------
    initial begin
        void'($urandom(33));
        Mclk          = 1'b0;
        ResetN        = 1'b0;
        AllPwrGd      = 1'b0;
        SystemOk      = 1'b0;
        BiosFinished  = 1'b0;
        BiosPostData  = '0;
        Strobe1ms     = 1'b0;
        Strobe1s      = 1'b0;
        Strobe125ms   = 1'b0;
        BiosStatus    = '0;
        SoftEn        = 1'b0;
        SoftSel       = '0;
        SoftVal       = '0;
        PowerEvtState = '0;
        DebugNibble   = '0;
        checkEn       = 1'b0;
        strobeRun     = 1'b0;
        errorCount    = 0;
        checkCount    = 0;
        selModel      = 0;
        modModel      = 2'd0;
        dpModel       = 1'b0;

        // Reset values, held in and just after reset
        testName = "reset";
        for (int c = 0; c < 11; c++) begin
            if (c == 8) begin
                @(negedge Mclk);
                ResetN = 1'b1;
            end
            @(posedge Mclk);
            #10;
            checkValue(testName, 8'(0), 8'(Led7En));
            checkValue(testName, 8'(SegAllOn), 8'(Led7Leg));
            checkValue(testName, 8'(0), 8'(Port80Dp));
        end
        strobeRun = 1'b1;

        // First visible step is position 0
        testName = "scan order";
        for (int i = 0; i < 2 * NumDigits; i++) begin
            waitEnChange();
            checkValue(testName, 8'(1 << (i % NumDigits)), 8'(Led7En));
        end

        // Post mode, modulate still at zero
        testName = "post mode";
        @(negedge Mclk);
        AllPwrGd     = 1'b1;
        BiosPostData = 8'($urandom);
        BiosStatus   = 3'($urandom);
        settle();
        checkRound();

        testName = "standby mode";
        @(negedge Mclk);
        AllPwrGd      = 1'b0;
        PowerEvtState = 4'($urandom);
        DebugNibble   = 4'($urandom);
        settle();
        checkRound();

        // Rotation through C, n, A and back
        testName = "banner rotate";
        @(negedge Mclk);
        AllPwrGd     = 1'b1;
        BiosFinished = 1'b1;
        BiosStatus   = 3'($urandom);
        settle();
        checkRound();
        repeat (3) begin
            pulseStrobe1s();
            settle();
            checkRound();
        end

        // Boot blink, dark at phase two
        testName = "banner blink";
        @(negedge Mclk);
        BiosFinished = 1'b0;
        pulseStrobe125ms();
        pulseStrobe125ms();
        settle();
        checkRound();

        testName = "software writes";
        latchStore();
        repeat (3) begin
            applySoft();
            settle();
            checkRound();
        end

        $display("checks %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: list.f
common/SegPkg.sv
scan/SegGlyphDecode.sv
scan/SegScanner.sv
rtl/SegBiosBanner.sv
rtl/SegDigitStore.sv
rtl/Led7SegDisplay.sv
bench/tbLed7Seg.sv

// File: run.sh
#!/bin/sh
# Build and run the display testbench with Verilator, from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module tbLed7Seg -Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "sim failed" sim.log; then
    exit 1
fi
exit 0
